// File: cam_pkg.sv
package cam_pkg;

  // camera active area, 720p
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;
  localparam logic [HCOUNT_W-1:0] CAM_H_ACTIVE = 11'd1280;
  localparam logic [VCOUNT_W-1:0] CAM_V_ACTIVE = 10'd720;

  // keep one pixel in four per axis
  localparam int DS_SHIFT = 2;

  // decimated frame buffer geometry
  localparam int FB_WIDTH  = 320;
  localparam int FB_HEIGHT = 180;
  localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
  localparam int FB_ADDR_W = $clog2(FB_DEPTH);
  localparam int PIXEL_W   = 16;

  // host bus
  localparam int AXIL_ADDR_W = 19;
  localparam int AXIL_DATA_W = 32;

  // register map, byte addresses
  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 19'h0_0000;
  localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 19'h0_0004;
  // set: bits 17..2 index the frame buffer
  localparam int PIXEL_WINDOW_BIT = 18;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // one rgb565 pixel
  // camera delivers it as two bytes, host side reads colour fields
  typedef union packed {
    struct packed {
      logic [PIXEL_W/2-1:0] hi;
      logic [PIXEL_W/2-1:0] lo;
    } bytes;
    struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
    } color;
  } pixel_u;

endpackage

// File: camera_capture_top.sv
module camera_capture_top import cam_pkg::*; (
  input  logic                     clk_camera,
  input  logic                     sys_rst_pixel,
  // camera pins, async to clk_camera
  input  logic [7:0]               cam_data_i,
  input  logic                     cam_pclk_i,
  input  logic                     cam_hsync_i,
  input  logic                     cam_vsync_i,
  // host port
  input  logic [AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  input  logic [AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i
);

  // rebuilt pixel stream
  logic                pixel_valid;
  pixel_u              pixel;
  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  logic                frame_start;

  // frame buffer ports
  logic                 fb_we;
  logic [FB_ADDR_W-1:0] fb_waddr;
  pixel_u               fb_wdata;
  logic [FB_ADDR_W-1:0] fb_raddr;
  pixel_u               fb_rdata;

  logic capture_en;

  pixel_reconstruct i_pixel_reconstruct (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .cam_data_i    (cam_data_i),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .pixel_valid_o (pixel_valid),
    .pixel_o       (pixel),
    .hcount_o      (hcount),
    .vcount_o      (vcount),
    .frame_start_o (frame_start)
  );

  frame_writer i_frame_writer (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .capture_en_i  (capture_en),
    .pixel_valid_i (pixel_valid),
    .pixel_i       (pixel),
    .hcount_i      (hcount),
    .vcount_i      (vcount),
    .fb_we_o       (fb_we),
    .fb_waddr_o    (fb_waddr),
    .fb_wdata_o    (fb_wdata)
  );

  frame_buffer i_frame_buffer (
    .clk_camera (clk_camera),
    .we_i       (fb_we),
    .waddr_i    (fb_waddr),
    .wdata_i    (fb_wdata),
    .raddr_i    (fb_raddr),
    .rdata_o    (fb_rdata)
  );

  fb_axil_slave i_fb_axil_slave (
    .clk_camera       (clk_camera),
    .sys_rst_pixel    (sys_rst_pixel),
    .frame_start_i    (frame_start),
    .fb_rdata_i       (fb_rdata),
    .capture_en_o     (capture_en),
    .fb_raddr_o       (fb_raddr),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i)
  );

endmodule

// File: fb_axil_slave.sv
module fb_axil_slave import cam_pkg::*; (
  input  logic                     clk_camera,
  input  logic                     sys_rst_pixel,
  input  logic                     frame_start_i,
  input  pixel_u                   fb_rdata_i,
  output logic                     capture_en_o,
  output logic [FB_ADDR_W-1:0]     fb_raddr_o,
  // write address and data
  input  logic [AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  // write response
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  // read
  input  logic [AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i
);

  logic        wr_ready, wr_hs;
  logic        rd_ready, rd_hs;
  logic        in_window;
  logic        win_pend, win_err;
  logic [15:0] frame_count;

  // aw and w accepted together
  assign s_axil_awready_o = wr_ready;
  assign s_axil_wready_o  = wr_ready;
  assign s_axil_arready_o = rd_ready;

  assign wr_hs = wr_ready && s_axil_awvalid_i && s_axil_wvalid_i;
  assign rd_hs = rd_ready && s_axil_arvalid_i;

  // window index goes straight to the ram address
  assign in_window  = s_axil_araddr_i[PIXEL_WINDOW_BIT];
  assign fb_raddr_o = s_axil_araddr_i[PIXEL_WINDOW_BIT-1:2];

  // wrapping count of frame starts since reset
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      frame_count <= '0;
    end else if (frame_start_i) begin
      frame_count <= frame_count + 1'b1;
    end
  end

  // write channel with one transfer outstanding
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      wr_ready        <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
      capture_en_o    <= 1'b0;
    end else begin
      if (s_axil_bvalid_o && s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
      if (wr_hs) begin
        wr_ready        <= 1'b0;
        s_axil_bvalid_o <= 1'b1;
        // only ctrl bit 0 is writable
        if (s_axil_awaddr_i == REG_CTRL && s_axil_wstrb_i[0]) begin
          capture_en_o <= s_axil_wdata_i[0];
        end
      end else if (s_axil_awvalid_i && s_axil_wvalid_i && !wr_ready && !s_axil_bvalid_o) begin
        wr_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (wr_hs) begin
      s_axil_bresp_o <= (s_axil_awaddr_i == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // read channel control
  // registers answer next cycle and the window waits one more for the ram
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      rd_ready        <= 1'b0;
      win_pend        <= 1'b0;
      s_axil_rvalid_o <= 1'b0;
    end else begin
      if (s_axil_rvalid_o && s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
      if (rd_hs) begin
        rd_ready <= 1'b0;
        if (in_window) begin
          win_pend <= 1'b1;
        end else begin
          s_axil_rvalid_o <= 1'b1;
        end
      end else if (s_axil_arvalid_i && !rd_ready && !s_axil_rvalid_o && !win_pend) begin
        rd_ready <= 1'b1;
      end
      if (win_pend) begin
        win_pend        <= 1'b0;
        s_axil_rvalid_o <= 1'b1;
      end
    end
  end

  // read data and response
  always_ff @(posedge clk_camera) begin
    if (rd_hs) begin
      win_err <= int'(fb_raddr_o) >= FB_DEPTH;
      if (!in_window) begin
        case (s_axil_araddr_i)
          REG_CTRL: begin
            s_axil_rdata_o <= {{(AXIL_DATA_W-1){1'b0}}, capture_en_o};
            s_axil_rresp_o <= RESP_OKAY;
          end
          REG_STATUS: begin
            s_axil_rdata_o <= {{(AXIL_DATA_W-16){1'b0}}, frame_count};
            s_axil_rresp_o <= RESP_OKAY;
          end
          default: begin
            s_axil_rdata_o <= '0;
            s_axil_rresp_o <= RESP_SLVERR;
          end
        endcase
      end
    end else if (win_pend) begin
      if (win_err) begin
        s_axil_rdata_o <= '0;
        s_axil_rresp_o <= RESP_SLVERR;
      end else begin
        // rgb565 to rgb888 with zeros in the low bits
        s_axil_rdata_o <= {8'h00,
                           fb_rdata_i.color.red,   3'b000,
                           fb_rdata_i.color.green, 2'b00,
                           fb_rdata_i.color.blue,  3'b000};
        s_axil_rresp_o <= RESP_OKAY;
      end
    end
  end

  // response and its payload held until the host takes it
  a_rvalid_held: assert property (
    @(posedge clk_camera) disable iff (sys_rst_pixel)
    s_axil_rvalid_o && !s_axil_rready_i |=>
      s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o)
  );

endmodule

// File: files.f
cam_pkg.sv
pixel_reconstruct.sv
frame_writer.sv
frame_buffer.sv
fb_axil_slave.sv
camera_capture_top.sv
tb_camera_capture.sv

// File: frame_buffer.sv
module frame_buffer import cam_pkg::*; (
  input  logic                 clk_camera,
  input  logic                 we_i,
  input  logic [FB_ADDR_W-1:0] waddr_i,
  input  pixel_u               wdata_i,
  input  logic [FB_ADDR_W-1:0] raddr_i,
  output pixel_u               rdata_o
);

  // simple dual-port, maps onto block ram
  logic [PIXEL_W-1:0] mem [FB_DEPTH];

  always_ff @(posedge clk_camera) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk_camera) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

// File: frame_writer.sv
module frame_writer import cam_pkg::*; (
  input  logic                 clk_camera,
  input  logic                 sys_rst_pixel,
  input  logic                 capture_en_i,
  input  logic                 pixel_valid_i,
  input  pixel_u               pixel_i,
  input  logic [HCOUNT_W-1:0]  hcount_i,
  input  logic [VCOUNT_W-1:0]  vcount_i,
  output logic                 fb_we_o,
  output logic [FB_ADDR_W-1:0] fb_waddr_o,
  output pixel_u               fb_wdata_o
);

  logic                 keep;
  logic [FB_ADDR_W-1:0] col;
  logic [FB_ADDR_W-1:0] row;

  // every fourth column and row inside the active area
  assign keep = capture_en_i && pixel_valid_i &&
                (hcount_i[DS_SHIFT-1:0] == '0) &&
                (vcount_i[DS_SHIFT-1:0] == '0) &&
                (hcount_i < CAM_H_ACTIVE) &&
                (vcount_i < CAM_V_ACTIVE);

  // decimated coordinates
  assign col = FB_ADDR_W'(hcount_i >> DS_SHIFT);
  assign row = FB_ADDR_W'(vcount_i >> DS_SHIFT);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      fb_we_o <= 1'b0;
    end else begin
      fb_we_o <= keep;
    end
  end

  // row-major, FB_WIDTH words per row
  always_ff @(posedge clk_camera) begin
    if (keep) begin
      fb_waddr_o <= col + FB_ADDR_W'(FB_WIDTH) * row;
      fb_wdata_o <= pixel_i;
    end
  end

  a_waddr_in_range: assert property (
    @(posedge clk_camera) disable iff (sys_rst_pixel)
    fb_we_o |-> (int'(fb_waddr_o) < FB_DEPTH)
  );

endmodule

// File: pixel_reconstruct.sv
module pixel_reconstruct import cam_pkg::*; (
  input  logic                clk_camera,
  input  logic                sys_rst_pixel,
  input  logic [7:0]          cam_data_i,
  input  logic                cam_pclk_i,
  input  logic                cam_hsync_i,
  input  logic                cam_vsync_i,
  output logic                pixel_valid_o,
  output pixel_u              pixel_o,
  output logic [HCOUNT_W-1:0] hcount_o,
  output logic [VCOUNT_W-1:0] vcount_o,
  output logic                frame_start_o
);

  // two-flop synchronizers plus a third flop for edge detect
  logic [7:0] data_s1, data_s2;
  logic [2:0] pclk_sr, hsync_sr, vsync_sr;

  logic pclk_rise, hsync_fall, vsync_rise;

  // byte phase and the high byte held until the low byte shows up
  logic       phase;
  logic [7:0] hi_byte;

  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      pclk_sr  <= '0;
      hsync_sr <= '0;
      vsync_sr <= '0;
    end else begin
      pclk_sr  <= {pclk_sr[1:0], cam_pclk_i};
      hsync_sr <= {hsync_sr[1:0], cam_hsync_i};
      vsync_sr <= {vsync_sr[1:0], cam_vsync_i};
    end
  end

  // bit 1 is the synchronized level and bit 2 its previous value
  assign pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
  assign hsync_fall = ~hsync_sr[1] & hsync_sr[2];
  assign vsync_rise = vsync_sr[1] & ~vsync_sr[2];

  // counters and byte phase
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      phase         <= 1'b0;
      hcount        <= '0;
      vcount        <= '0;
      pixel_valid_o <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      pixel_valid_o <= 1'b0;
      frame_start_o <= vsync_rise;
      if (vsync_rise) begin
        // new frame restarts everything
        phase  <= 1'b0;
        hcount <= '0;
        vcount <= '0;
      end else if (hsync_fall) begin
        // end of line
        phase  <= 1'b0;
        hcount <= '0;
        vcount <= vcount + 1'b1;
      end else if (hsync_sr[1] && pclk_rise) begin
        phase <= ~phase;
        if (phase) begin
          pixel_valid_o <= 1'b1;
          hcount        <= hcount + 1'b1;
        end
      end
    end
  end

  // payload only meaningful with pixel_valid_o
  always_ff @(posedge clk_camera) begin
    if (hsync_sr[1] && pclk_rise) begin
      if (!phase) begin
        hi_byte <= data_s2;
      end else begin
        pixel_o.bytes.hi <= hi_byte;
        pixel_o.bytes.lo <= data_s2;
        hcount_o         <= hcount;
        vcount_o         <= vcount;
      end
    end
  end

  // each pixel takes two pclk rises and rises come two cycles apart at best
  a_no_back_to_back: assert property (
    @(posedge clk_camera) disable iff (sys_rst_pixel)
    pixel_valid_o |-> !$past(pixel_valid_o) && !$past(pixel_valid_o, 2) &&
                      !$past(pixel_valid_o, 3)
  );

endmodule

// File: tb_camera_capture.sv
module tb_camera_capture import cam_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // stimulus shape, four frames over the whole run
  localparam int FRAME_LINES      = 5;
  localparam int LINE_PIXELS      = 8;
  localparam int NUM_FRAMES       = 4;
  localparam int CYCLES_PER_PIXEL = 8;
  localparam int TIMEOUT_CYCLES   =
    2 * (NUM_FRAMES * FRAME_LINES * LINE_PIXELS * CYCLES_PER_PIXEL) + 2000;
  localparam int DRIVE_DLY        = 2;

  logic                     clk_camera;
  logic                     sys_rst_pixel;
  logic [7:0]               cam_data;
  logic                     cam_pclk;
  logic                     cam_hsync;
  logic                     cam_vsync;
  logic [AXIL_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [AXIL_DATA_W-1:0]   wdata;
  logic [AXIL_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [AXIL_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [AXIL_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  // words of the last frame sent while capture was on, [line][pixel]
  logic [15:0] captured [FRAME_LINES][LINE_PIXELS];
  logic        capture_on;
  int          cycle_count;

  camera_capture_top i_camera_capture_top (
    .clk_camera       (clk_camera),
    .sys_rst_pixel    (sys_rst_pixel),
    .cam_data_i       (cam_data),
    .cam_pclk_i       (cam_pclk),
    .cam_hsync_i      (cam_hsync),
    .cam_vsync_i      (cam_vsync),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  // 40 ns period
  always #20 clk_camera = ~clk_camera;

  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  // rgb565 to rgb888, low bits zero
  function automatic logic [23:0] expand_rgb565(input logic [15:0] w);
    return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
  endfunction

  // byte address of a frame buffer index
  function automatic logic [AXIL_ADDR_W-1:0] window_addr(input int idx);
    return AXIL_ADDR_W'(1 << PIXEL_WINDOW_BIT) | AXIL_ADDR_W'(idx << 2);
  endfunction

  task automatic check_pixel(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [AXIL_DATA_W-1:0] got,
                            input logic [AXIL_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_camera);
    #DRIVE_DLY;
  endtask

  task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // both readies rise together
    do @(posedge clk_camera); while (!(awready && wready));
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    do @(posedge clk_camera); while (!bvalid);
    resp = bresp;
    #DRIVE_DLY;
    bready = 1'b0;
  endtask

  // hold_cycles keeps rready low after the address phase
  task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, input int hold_cycles,
                           output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    do @(posedge clk_camera); while (!arready);
    #DRIVE_DLY;
    arvalid = 1'b0;
    if (hold_cycles > 0) begin
      repeat (hold_cycles) next_cycle();
      if (!rvalid) begin
        $display("read response not held while rready was low at %0t ns", $time);
        abort_run();
      end
    end
    rready = 1'b1;
    do @(posedge clk_camera); while (!rvalid);
    data = rdata;
    resp = rresp;
    #DRIVE_DLY;
    rready = 1'b0;
  endtask

  // one byte, each pclk level held two cycles
  task automatic send_byte(input logic [7:0] b);
    cam_data = b;
    cam_pclk = 1'b0;
    repeat (2) next_cycle();
    cam_pclk = 1'b1;
    repeat (2) next_cycle();
  endtask

  task automatic send_frame();
    logic [15:0] word;
    cam_vsync = 1'b1;
    repeat (4) next_cycle();
    cam_vsync = 1'b0;
    repeat (4) next_cycle();
    for (int v = 0; v < FRAME_LINES; v++) begin
      cam_hsync = 1'b1;
      repeat (2) next_cycle();
      for (int h = 0; h < LINE_PIXELS; h++) begin
        word = 16'($urandom);
        if (capture_on) begin
          captured[v][h] = word;
        end
        // high byte goes first
        send_byte(word[15:8]);
        send_byte(word[7:0]);
      end
      cam_hsync = 1'b0;
      // junk between lines
      repeat (3) send_byte(8'($urandom));
    end
    // settle time for the last pixel
    repeat (20) next_cycle();
  endtask

  task automatic check_captured(input int h, input int v);
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_read(window_addr(h / 4 + 320 * (v / 4)), 0, data, resp);
    check_resp($sformatf("rresp pixel (%0d,%0d)", h, v), resp, RESP_OKAY);
    check_pixel($sformatf("rdata pixel (%0d,%0d)", h, v), data[23:0],
                expand_rgb565(captured[v][h]));
  endtask

  task automatic check_status(input int frames);
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_read(REG_STATUS, 0, data, resp);
    check_resp("rresp status", resp, RESP_OKAY);
    check_word("rdata status", data, AXIL_DATA_W'(frames));
  endtask

  task automatic check_four_pixels();
    check_captured(0, 0);
    check_captured(4, 0);
    check_captured(0, 4);
    check_captured(4, 4);
  endtask

  task automatic test_reset_values();
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_read(REG_CTRL, 0, data, resp);
    check_resp("rresp ctrl", resp, RESP_OKAY);
    check_word("rdata ctrl", data, '0);
    check_status(0);
  endtask

  task automatic test_capture();
    logic [1:0] resp;
    axil_write(REG_CTRL, 32'h1, resp);
    check_resp("bresp ctrl", resp, RESP_OKAY);
    capture_on = 1'b1;
    send_frame();
    check_four_pixels();
  endtask

  task automatic test_frame_count();
    send_frame();
    send_frame();
    check_status(3);
    check_four_pixels();
  endtask

  task automatic test_capture_disabled();
    logic [1:0] resp;
    axil_write(REG_CTRL, 32'h0, resp);
    check_resp("bresp ctrl", resp, RESP_OKAY);
    capture_on = 1'b0;
    send_frame();
    // buffer keeps the third frame, counter still runs
    check_four_pixels();
    check_status(4);
  endtask

  task automatic test_refused_access();
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_write(REG_STATUS, 32'h1234, resp);
    check_resp("bresp status write", resp, RESP_SLVERR);
    axil_read(AXIL_ADDR_W'(8), 0, data, resp);
    check_resp("rresp offset 8", resp, RESP_SLVERR);
    check_word("rdata offset 8", data, '0);
    axil_read(window_addr(FB_DEPTH), 0, data, resp);
    check_resp("rresp window end", resp, RESP_SLVERR);
    check_word("rdata window end", data, '0);
  endtask

  task automatic test_backpressure();
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_read(window_addr(1 + 320), 10, data, resp);
    check_resp("rresp held read", resp, RESP_OKAY);
    check_pixel("rdata held read", data[23:0], expand_rgb565(captured[4][4]));
  endtask

  initial begin
    void'($urandom(32'h0ec8b9c5));
    clk_camera    = 1'b0;
    sys_rst_pixel = 1'b1;
    cam_data      = '0;
    cam_pclk      = 1'b0;
    cam_hsync     = 1'b0;
    cam_vsync     = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    capture_on    = 1'b0;
    cycle_count   = 0;
    repeat (4) @(posedge clk_camera);
    #DRIVE_DLY;
    sys_rst_pixel = 1'b0;
    next_cycle();

    test_reset_values();
    test_capture();
    test_frame_count();
    test_capture_disabled();
    test_refused_access();
    test_backpressure();

    $display("All tests passed!");
    $finish;
  end

endmodule
